// File: core_frontend.f
fe_pkg.sv
fe_npc.sv
fe_ifetch.sv
fe_inst_queue.sv
fe_decoder.sv
fe_issue_buf.sv
core_frontend.sv
core_frontend_properties.sv
tb_core_frontend.sv

// File: core_frontend.sv
`timescale 1ns/100ps

module core_frontend import fe_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  fe_ctrl_t  ctrl_i,
  input  bus_resp_t bus_resp_i,
  output bus_req_t  bus_req_o,
  output fe_out_t   out_o
);

  logic [31:0]      pc;
  logic [1:0]       slot_mask;
  logic             fetch_en;
  logic             take;
  logic             queue_room;
  logic [1:0]       wr_count;
  fetch_pkt_t [1:0] wr_pkt;
  logic [1:0]       rd_valid;
  fetch_pkt_t [1:0] rd_pkt;
  logic [1:0]       rd_count;

  fe_npc i_npc (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (ctrl_i.redirect),
    .redirect_pc_i (ctrl_i.redirect_pc),
    .wait_inst_i   (ctrl_i.wait_inst),
    .int_detect_i  (ctrl_i.int_detect),
    .take_i        (take),
    .pc_o          (pc),
    .slot_mask_o   (slot_mask),
    .fetch_en_o    (fetch_en)
  );

  fe_ifetch i_ifetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc),
    .slot_mask_i  (slot_mask),
    .fetch_en_i   (fetch_en),
    .flush_i      (ctrl_i.redirect),
    .queue_room_i (queue_room),
    .bus_resp_i   (bus_resp_i),
    .take_o       (take),
    .bus_req_o    (bus_req_o),
    .wr_count_o   (wr_count),
    .wr_pkt_o     (wr_pkt)
  );

  fe_inst_queue i_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (ctrl_i.redirect),
    .wr_count_i (wr_count),
    .wr_pkt_i   (wr_pkt),
    .rd_count_i (rd_count),
    .room_o     (queue_room),
    .rd_valid_o (rd_valid),
    .rd_pkt_o   (rd_pkt)
  );

  fe_issue_buf i_issue_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (ctrl_i.redirect),
    .issue_i    (ctrl_i.issue),
    .rd_valid_i (rd_valid),
    .rd_pkt_i   (rd_pkt),
    .rd_count_o (rd_count),
    .out_o      (out_o)
  );

endmodule

// File: core_frontend_properties.sv
`timescale 1ns/100ps

module core_frontend_properties import fe_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input bus_req_t  bus_req_i,
  input bus_resp_t bus_resp_i,
  input fe_out_t   out_i,
  input fe_ctrl_t  ctrl_i
);

  int   fail_count = 0;
  logic lock_ref;

  // idle lock as seen from the back-end controls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lock_ref <= 1'b0;
    end else if (ctrl_i.int_detect) begin
      lock_ref <= 1'b0;
    end else if (ctrl_i.wait_inst) begin
      lock_ref <= 1'b1;
    end
  end

  // address held until the response strobe ends the transfer
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i.valid && !bus_resp_i.valid |=> bus_req_i.valid && $stable(bus_req_i.addr))
    else begin
      $error("bus request dropped or changed address before the response");
      fail_count++;
    end

  // slot 1 never valid without slot 0
  valid_order: assert property (@(posedge clk) disable iff (!rst_n)
    out_i.inst_valid != 2'b10)
    else begin
      $error("inst_valid is 10");
      fail_count++;
    end

  no_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(bus_req_i.valid) |-> !lock_ref)
    else begin
      $error("bus request rose under the idle lock");
      fail_count++;
    end

endmodule

bind core_frontend core_frontend_properties i_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .bus_req_i  (bus_req_o),
  .bus_resp_i (bus_resp_i),
  .out_i      (out_o),
  .ctrl_i     (ctrl_i)
);

// File: fe_decoder.sv
`timescale 1ns/100ps

module fe_decoder import fe_pkg::*; (
  input  inst_word_u inst_i,
  output decode_t    dec_o
);

  op_class_e op;

  // 3R and 2RI12 opcodes sit in the register view, branches in the offset view
  always_comb begin
    if (inst_i.regs.opcode == OP_ADD_W) begin
      op = ADD;
    end else if (inst_i.regs.opcode[16:7] == OP_ADDI_W) begin
      op = ADDI;
    end else if (inst_i.regs.opcode[16:7] == OP_ST_W) begin
      op = ST;
    end else if (inst_i.offs.opcode == OP_B) begin
      op = B;
    end else if (inst_i.offs.opcode == OP_BL) begin
      op = BL;
    end else begin
      op = INVALID;
    end
  end

  // register selection per class
  always_comb begin
    dec_o.op_class = op;
    dec_o.imm      = inst_i.offs.offs;
    dec_o.reg_info = '0;
    case (op)
      ADD: begin
        dec_o.reg_info.r0 = inst_i.regs.rk;
        dec_o.reg_info.r1 = inst_i.regs.rj;
        dec_o.reg_info.w  = inst_i.regs.rd;
      end
      ADDI: begin
        dec_o.reg_info.r1 = inst_i.regs.rj;
        dec_o.reg_info.w  = inst_i.regs.rd;
      end
      ST: begin
        // store data comes from rd
        dec_o.reg_info.r0 = inst_i.regs.rd;
        dec_o.reg_info.r1 = inst_i.regs.rj;
      end
      BL: begin
        // link register
        dec_o.reg_info.w = 5'd1;
      end
      default: begin
        dec_o.reg_info = '0;
      end
    endcase
  end

endmodule

// File: fe_ifetch.sv
`timescale 1ns/100ps

module fe_ifetch import fe_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [31:0]      pc_i,
  input  logic [1:0]       slot_mask_i,
  input  logic             fetch_en_i,
  input  logic             flush_i,
  input  logic             queue_room_i,
  input  bus_resp_t        bus_resp_i,
  output logic             take_o,
  output bus_req_t         bus_req_o,
  output logic [1:0]       wr_count_o,
  output fetch_pkt_t [1:0] wr_pkt_o
);

  typedef enum logic {
    S_IDLE,
    S_BUSY
  } state_e;

  state_e      state_q;
  logic [31:0] addr_q;
  logic [1:0]  mask_q;
  logic        drop_q;
  logic        start;
  logic        resp_done;

  // a new block goes out only with room for a full block in the queue
  assign start     = (state_q == S_IDLE) && fetch_en_i && queue_room_i && !flush_i;
  assign resp_done = (state_q == S_BUSY) && bus_resp_i.valid;
  assign take_o    = start;

  // request rises in the start cycle, then holds the latched address
  assign bus_req_o.valid = start || (state_q == S_BUSY);
  assign bus_req_o.addr  = (state_q == S_BUSY) ? addr_q : {pc_i[31:3], 3'b000};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      drop_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start) begin
            state_q <= S_BUSY;
            drop_q  <= 1'b0;
          end
        end
        default: begin
          if (bus_resp_i.valid) begin
            state_q <= S_IDLE;
            drop_q  <= 1'b0;
          end else if (flush_i) begin
            // response still owed, throw it away when it comes
            drop_q <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= {pc_i[31:3], 3'b000};
      mask_q <= slot_mask_i;
    end
  end

  // slot 0 always carries the lowest valid word
  assign wr_pkt_o[0].pc   = {addr_q[31:3], ~mask_q[0], 2'b00};
  assign wr_pkt_o[0].inst = mask_q[0] ? bus_resp_i.data[31:0] : bus_resp_i.data[63:32];
  assign wr_pkt_o[1].pc   = {addr_q[31:3], 3'b100};
  assign wr_pkt_o[1].inst = bus_resp_i.data[63:32];

  assign wr_count_o = (resp_done && !drop_q && !flush_i)
                    ? ({1'b0, mask_q[0]} + {1'b0, mask_q[1]})
                    : 2'd0;

endmodule

// File: fe_inst_queue.sv
`timescale 1ns/100ps

module fe_inst_queue import fe_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic [1:0]       wr_count_i,
  input  fetch_pkt_t [1:0] wr_pkt_i,
  input  logic [1:0]       rd_count_i,
  output logic             room_o,
  output logic [1:0]       rd_valid_o,
  output fetch_pkt_t [1:0] rd_pkt_o
);

  // entry at pointer p lives in bank p[0], row p[QPTR_W-1:1]
  fetch_pkt_t mem [2][BANK_DEPTH];

  logic [QPTR_W-1:0] wr_ptr_q;
  logic [QPTR_W-1:0] rd_ptr_q;
  logic [QPTR_W-1:0] wr_ptr1;
  logic [QPTR_W-1:0] rd_ptr1;
  logic [QPTR_W:0]   count_q;
  logic [1:0]        bank_we;
  logic [QPTR_W-2:0] bank_row [2];
  fetch_pkt_t        bank_wdata [2];

  assign wr_ptr1 = wr_ptr_q + 1'b1;
  assign rd_ptr1 = rd_ptr_q + 1'b1;

  // consecutive pointers differ in parity, so each bank takes at most one write
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      if (wr_ptr_q[0] == b[0]) begin
        bank_we[b]    = (wr_count_i != 2'd0);
        bank_row[b]   = wr_ptr_q[QPTR_W-1:1];
        bank_wdata[b] = wr_pkt_i[0];
      end else begin
        bank_we[b]    = (wr_count_i == 2'd2);
        bank_row[b]   = wr_ptr1[QPTR_W-1:1];
        bank_wdata[b] = wr_pkt_i[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (bank_we[b]) begin
        mem[b][bank_row[b]] <= bank_wdata[b];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + QPTR_W'(wr_count_i);
      rd_ptr_q <= rd_ptr_q + QPTR_W'(rd_count_i);
      count_q  <= count_q + (QPTR_W+1)'(wr_count_i) - (QPTR_W+1)'(rd_count_i);
    end
  end

  // two oldest entries, slot 0 is the head
  assign rd_pkt_o[0] = mem[rd_ptr_q[0]][rd_ptr_q[QPTR_W-1:1]];
  assign rd_pkt_o[1] = mem[rd_ptr1[0]][rd_ptr1[QPTR_W-1:1]];

  assign rd_valid_o = {count_q >= (QPTR_W+1)'(2), count_q != '0};
  assign room_o     = count_q <= (QPTR_W+1)'(QUEUE_DEPTH - 2);

endmodule

// File: fe_issue_buf.sv
`timescale 1ns/100ps

module fe_issue_buf import fe_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic [1:0]       issue_i,
  input  logic [1:0]       rd_valid_i,
  input  fetch_pkt_t [1:0] rd_pkt_i,
  output logic [1:0]       rd_count_o,
  output fe_out_t          out_o
);

  decode_t [1:0]     head_dec;
  issue_slot_t [1:0] head;
  issue_slot_t [1:0] slot_q;
  issue_slot_t [1:0] slot_d;
  logic [1:0]        valid_q;
  logic [1:0]        valid_d;
  logic [1:0]        keep;

  for (genvar p = 0; p < 2; p++) begin : g_dec
    fe_decoder i_decoder (
      .inst_i (rd_pkt_i[p].inst),
      .dec_o  (head_dec[p])
    );
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      head[p].pkt = rd_pkt_i[p];
      head[p].dec = head_dec[p];
    end
  end

  // how many held instructions survive this cycle
  always_comb begin
    if (valid_q[1]) begin
      keep = !issue_i[0] ? 2'd2 : (!issue_i[1] ? 2'd1 : 2'd0);
    end else if (valid_q[0]) begin
      keep = issue_i[0] ? 2'd0 : 2'd1;
    end else begin
      keep = 2'd0;
    end
  end

  // survivors move down, free slots refill from the queue head in order
  always_comb begin
    slot_d     = slot_q;
    valid_d    = valid_q;
    rd_count_o = 2'd0;
    case (keep)
      2'd2: begin
        valid_d = 2'b11;
      end
      2'd1: begin
        if (valid_q[1]) begin
          slot_d[0] = slot_q[1];
        end
        slot_d[1]  = head[0];
        valid_d    = {rd_valid_i[0], 1'b1};
        rd_count_o = {1'b0, rd_valid_i[0]};
      end
      default: begin
        slot_d     = head;
        valid_d    = rd_valid_i;
        rd_count_o = {1'b0, rd_valid_i[0]} + {1'b0, rd_valid_i[1]};
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 2'b00;
    end else if (flush_i) begin
      valid_q <= 2'b00;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= slot_d;
  end

  assign out_o.inst_valid = valid_q;
  assign out_o.inst       = slot_q;

endmodule

// File: fe_npc.sv
`timescale 1ns/100ps

module fe_npc import fe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  input  logic        wait_inst_i,
  input  logic        int_detect_i,
  input  logic        take_i,
  output logic [31:0] pc_o,
  output logic [1:0]  slot_mask_o,
  output logic        fetch_en_o
);

  logic [31:0] pc_q;
  logic        lock_q;

  // redirect wins over a sequential advance
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (take_i) begin
      pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
    end
  end

  // idle lock, an interrupt in the same cycle keeps it open
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lock_q <= 1'b0;
    end else if (wait_inst_i && !int_detect_i) begin
      lock_q <= 1'b1;
    end else if (int_detect_i) begin
      lock_q <= 1'b0;
    end
  end

  assign pc_o        = pc_q;
  // upper slot only when entering mid-block
  assign slot_mask_o = pc_q[2] ? 2'b10 : 2'b11;
  assign fetch_en_o  = !lock_q;

endmodule

// File: fe_pkg.sv
package fe_pkg;

  // fetch starts here after reset
  localparam logic [31:0] RESET_PC = 32'h1c000000;

  // instruction queue geometry, two banks selected by pointer parity
  localparam int QUEUE_DEPTH = 16;
  localparam int BANK_DEPTH  = QUEUE_DEPTH / 2;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

  // 3R format, compared against inst[31:15]
  localparam logic [16:0] OP_ADD_W  = 17'h00020;
  // 2RI12 format, compared against inst[31:22]
  localparam logic [9:0]  OP_ADDI_W = 10'b0000001010;
  localparam logic [9:0]  OP_ST_W   = 10'b0010100110;
  // I26 format, compared against inst[31:26]
  localparam logic [5:0]  OP_B      = 6'b010100;
  localparam logic [5:0]  OP_BL     = 6'b010101;

  // register view of an instruction word
  typedef struct packed {
    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
  } inst_regs_t;

  // offset view, used by the branch formats
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] offs;
  } inst_offs_t;

  typedef union packed {
    inst_regs_t regs;
    inst_offs_t offs;
  } inst_word_u;

  typedef enum logic [2:0] {
    ADD,
    ADDI,
    ST,
    B,
    BL,
    INVALID
  } op_class_e;

  typedef struct packed {
    logic [4:0] r0;
    logic [4:0] r1;
    logic [4:0] w;
  } reg_info_t;

  typedef struct packed {
    op_class_e   op_class;
    reg_info_t   reg_info;
    logic [25:0] imm;
  } decode_t;

  // one queue entry
  typedef struct packed {
    logic [31:0] pc;
    inst_word_u  inst;
  } fetch_pkt_t;

  typedef struct packed {
    fetch_pkt_t pkt;
    decode_t    dec;
  } issue_slot_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } bus_req_t;

  // low word belongs to the lower address
  typedef struct packed {
    logic        valid;
    logic [63:0] data;
  } bus_resp_t;

  typedef struct packed {
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        wait_inst;
    logic        int_detect;
    // thermometer coded: 00 none, 01 slot 0, 11 both
    logic [1:0]  issue;
  } fe_ctrl_t;

  typedef struct packed {
    logic [1:0]        inst_valid;
    issue_slot_t [1:0] inst;
  } fe_out_t;

endpackage

// File: tb_core_frontend.sv
`timescale 1ns/100ps

module tb_core_frontend import fe_pkg::*; ();

  localparam logic [31:0] SEED = 32'hf78ddc4c;

  logic      clk = 1'b0;
  logic      rst_n = 1'b0;
  fe_ctrl_t  ctrl = '0;
  bus_resp_t bus_resp = '0;
  bus_req_t  bus_req;
  fe_out_t   out;

  // bus model state
  logic        bus_busy = 1'b0;
  logic [2:0]  bus_cnt = '0;
  logic [31:0] bus_addr = '0;
  logic [31:0] bus_rand = SEED;
  logic [31:0] stim_rand = SEED;

  // reference model and collector state
  logic [31:0] exp_pc = RESET_PC;
  logic [31:0] acc_pc [$];
  logic [5:0]  class_seen = '0;
  int          errors = 0;
  int          checks = 0;
  int          total;

  core_frontend i_core_frontend (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl_i     (ctrl),
    .bus_resp_i (bus_resp),
    .bus_req_o  (bus_req),
    .out_o      (out)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // folds the upper half down so every address bit reaches the low bits
  function automatic logic [31:0] addr_hash(input logic [31:0] addr);
    logic [31:0] h;
    h = lcg_next(addr ^ SEED);
    h = h ^ {h[15:0], h[31:16]};
    return lcg_next(h);
  endfunction

  // 0 add.w, 1 addi.w, 2 st.w, 3 b, 4 bl, 5 undefined
  function automatic int class_at(input logic [31:0] addr);
    logic [31:0] h;
    h = addr_hash(addr);
    return int'(h[23:16]) % 6;
  endfunction

  // memory word with register and offset fields hashed from the address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] h;
    h = lcg_next(addr_hash(addr));
    case (class_at(addr))
      0:       return 32'h00100000 | {17'd0, h[14:0]};
      1:       return 32'h02800000 | {10'd0, h[21:0]};
      2:       return 32'h29800000 | {10'd0, h[21:0]};
      3:       return 32'h50000000 | {6'd0, h[25:0]};
      4:       return 32'h54000000 | {6'd0, h[25:0]};
      default: return 32'hfc000000 | {6'd0, h[25:0]};
    endcase
  endfunction

  function automatic logic [1:0] issue_pattern(input logic [31:0] r);
    case (r[31:16] % 3)
      0:       return 2'b00;
      1:       return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // compare one accepted slot with the expected stream and the decode rules
  task automatic record_accept(input issue_slot_t sl);
    logic [31:0] word;
    op_class_e   exp_class;
    reg_info_t   exp_regs;
    int          cls;
    checks++;
    if (sl.pkt.pc != exp_pc) begin
      flag_error($sformatf("accepted pc %h, expected %h", sl.pkt.pc, exp_pc));
    end
    word     = word_at(sl.pkt.pc);
    cls      = class_at(sl.pkt.pc);
    exp_regs = '0;
    case (cls)
      0: begin
        exp_class   = ADD;
        exp_regs.r0 = word[14:10];
        exp_regs.r1 = word[9:5];
        exp_regs.w  = word[4:0];
      end
      1: begin
        exp_class   = ADDI;
        exp_regs.r1 = word[9:5];
        exp_regs.w  = word[4:0];
      end
      2: begin
        exp_class   = ST;
        exp_regs.r0 = word[4:0];
        exp_regs.r1 = word[9:5];
      end
      3: exp_class = B;
      4: begin
        exp_class  = BL;
        exp_regs.w = 5'd1;
      end
      default: exp_class = INVALID;
    endcase
    if (sl.pkt.inst != word) begin
      flag_error($sformatf("pc %h word %h, expected %h", sl.pkt.pc, sl.pkt.inst, word));
    end
    if (sl.dec.op_class != exp_class || sl.dec.reg_info != exp_regs) begin
      flag_error($sformatf("pc %h decode class %0d regs %h, expected class %0d regs %h",
                           sl.pkt.pc, int'(sl.dec.op_class), sl.dec.reg_info,
                           int'(exp_class), exp_regs));
    end
    if (sl.dec.imm != word[25:0]) begin
      flag_error($sformatf("pc %h imm %h, expected %h", sl.pkt.pc, sl.dec.imm, word[25:0]));
    end
    class_seen[cls] = 1'b1;
    acc_pc.push_back(sl.pkt.pc);
    exp_pc = sl.pkt.pc + 32'd4;
  endtask

  // inputs seen before the edge decide what the back end accepted
  always @(posedge clk) begin
    if (rst_n) begin
      if (ctrl.redirect) begin
        exp_pc = ctrl.redirect_pc;
      end else begin
        if (out.inst_valid[0] && ctrl.issue[0]) begin
          record_accept(out.inst[0]);
        end
        if (out.inst_valid[1] && ctrl.issue == 2'b11) begin
          record_accept(out.inst[1]);
        end
      end
    end
  end

  // bus model answers one transfer at a time after 1 to 4 cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      bus_resp <= '0;
      bus_busy <= 1'b0;
    end else if (bus_resp.valid) begin
      bus_resp.valid <= 1'b0;
    end else if (bus_busy) begin
      if (bus_cnt == 3'd1) begin
        bus_resp.valid <= 1'b1;
        bus_resp.data  <= {word_at(bus_addr + 32'd4), word_at(bus_addr)};
        bus_busy       <= 1'b0;
      end else begin
        bus_cnt <= bus_cnt - 3'd1;
      end
    end else if (bus_req.valid) begin
      bus_rand = lcg_next(bus_rand);
      bus_busy <= 1'b1;
      bus_addr <= bus_req.addr;
      bus_cnt  <= {1'b0, bus_rand[17:16]} + 3'd1;
    end
  end

  task automatic wait_accepts(input int count, input int limit, input string what);
    int target;
    int n;
    target = acc_pc.size() + count;
    n      = 0;
    while (acc_pc.size() < target && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (acc_pc.size() < target) begin
      errors++;
      $display("timeout after %0d cycles: too few instructions accepted in %s", limit, what);
    end
  endtask

  task automatic pulse_redirect(input logic [31:0] target, output int first_idx);
    @(posedge clk);
    ctrl.redirect    <= 1'b1;
    ctrl.redirect_pc <= target;
    ctrl.issue       <= 2'b00;
    @(posedge clk);
    first_idx     = acc_pc.size();
    ctrl.redirect <= 1'b0;
    ctrl.issue    <= 2'b11;
  endtask

  task automatic check_first_pc(input int idx, input logic [31:0] target);
    checks++;
    if (acc_pc.size() > idx && acc_pc[idx] != target) begin
      flag_error($sformatf("first pc after redirect %h, expected %h", acc_pc[idx], target));
    end
  endtask

  task automatic sequential_fetch();
    @(posedge clk);
    ctrl.issue <= 2'b11;
    wait_accepts(40, 400, "sequential fetch");
    checks++;
    if (acc_pc.size() > 0 && acc_pc[0] != RESET_PC) begin
      flag_error($sformatf("first pc %h, expected %h", acc_pc[0], RESET_PC));
    end
  endtask

  task automatic decode_mix();
    int n;
    n = 0;
    while (class_seen != 6'h3f && n < 1000) begin
      @(negedge clk);
      n++;
    end
    if (class_seen != 6'h3f) begin
      errors++;
      $display("timeout: not every instruction class was issued, seen mask %b", class_seen);
    end
  endtask

  task automatic back_pressure();
    int target;
    int n;
    target = acc_pc.size() + 60;
    n      = 0;
    while (acc_pc.size() < target && n < 3000) begin
      @(posedge clk);
      stim_rand = lcg_next(stim_rand);
      ctrl.issue <= issue_pattern(stim_rand);
      @(negedge clk);
      n++;
    end
    if (acc_pc.size() < target) begin
      errors++;
      $display("timeout: back-pressure run accepted too few instructions");
    end
    @(posedge clk);
    ctrl.issue <= 2'b11;
  endtask

  task automatic redirect_aligned();
    int          idx;
    logic [31:0] target;
    for (int k = 0; k < 3; k++) begin
      stim_rand = lcg_next(stim_rand);
      repeat (int'(stim_rand[18:16]) + 1) @(posedge clk);
      target = 32'h1c001000 + 32'(k) * 32'h100;
      pulse_redirect(target, idx);
      wait_accepts(24, 400, "aligned redirect");
      check_first_pc(idx, target);
    end
  endtask

  task automatic redirect_odd();
    int idx;
    pulse_redirect(32'h1c002004, idx);
    wait_accepts(1, 200, "odd redirect");
    check_first_pc(idx, 32'h1c002004);
    wait_accepts(10, 200, "stream after odd redirect");
  endtask

  task automatic idle_lock();
    logic prev;
    logic cur;
    @(posedge clk);
    ctrl.wait_inst <= 1'b1;
    @(posedge clk);
    ctrl.wait_inst <= 1'b0;
    prev = bus_req.valid;
    // a transfer already started may finish but no new one may begin
    repeat (30) begin
      @(posedge clk);
      cur = bus_req.valid;
      checks++;
      if (cur && !prev) begin
        flag_error("bus request started while the idle lock was set");
      end
      prev = cur;
    end
    @(posedge clk);
    ctrl.int_detect <= 1'b1;
    @(posedge clk);
    ctrl.int_detect <= 1'b0;
    wait_accepts(16, 400, "fetch after interrupt");
  endtask

  initial begin
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    sequential_fetch();
    decode_mix();
    back_pressure();
    redirect_aligned();
    redirect_odd();
    idle_lock();
    repeat (5) @(posedge clk);
    total = errors + i_core_frontend.i_properties.fail_count;
    $display("%0d errors in %0d checks", total, checks);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
